// File: bpPkg.sv
/*
 * Branch predictor shared definitions
 * Opcodes, two-bit counter encoding, reset PC and the
 * B-type/J-type view of one instruction word
 */
`default_nettype none

package bpPkg;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    // Saturating counter states, prediction is the top bit
    localparam logic [1:0] CNT_STRONG_NT = 2'b00;
    localparam logic [1:0] CNT_WEAK_NT   = 2'b01;
    localparam logic [1:0] CNT_WEAK_T    = 2'b10;
    localparam logic [1:0] CNT_STRONG_T  = 2'b11;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jType;
    } brFormat_u;

endpackage

`default_nettype wire

// File: bpIfaces.sv
/*
 * Pipeline bundles for the branch predicting front end
 * stageBus moves one instruction between stages,
 * trainBus carries resolved outcomes to the predictor tables
 */
`timescale 1ns/10ps
`default_nettype none

interface stageBus #(
    parameter int PHT_ENTRIES = 1024
);
    localparam int IDX_BITS = $clog2(PHT_ENTRIES);

    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         instr;
    logic                actualTaken;
    logic                predTaken;
    logic [31:0]         predTarget;
    logic [IDX_BITS-1:0] phtIndex;
    // Computed branch or jump target, valid from decode onward
    logic [31:0]         target;

    modport sender (output valid, pc, instr, actualTaken, predTaken, predTarget,
                    phtIndex, target);
    modport receiver (input valid, pc, instr, actualTaken, predTaken, predTarget,
                      phtIndex, target);
endinterface

interface trainBus #(
    parameter int PHT_ENTRIES = 1024
);
    localparam int IDX_BITS = $clog2(PHT_ENTRIES);

    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         target;
    logic                isBranch;
    logic                taken;
    logic [IDX_BITS-1:0] phtIndex;

    modport sender (output valid, pc, target, isBranch, taken, phtIndex);
    modport receiver (input valid, pc, target, isBranch, taken, phtIndex);
endinterface

`default_nettype wire

// File: branchTargetBuffer.sv
/*
 * Direct-mapped branch target buffer
 * Combinational lookup by fetch PC, written at resolve
 * for jumps and taken branches
 */
`timescale 1ns/10ps
`default_nettype none

module branchTargetBuffer #(
    parameter int BTB_ENTRIES = 32
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [31:0] lookupPc_i,
    output logic             hit_o,
    output logic [31:0]      target_o,
    output logic             isBranch_o,
    trainBus.receiver        train
);
    localparam int IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = 30 - IDX_BITS;

    logic [BTB_ENTRIES-1:0] entryValid;
    logic [TAG_BITS-1:0]    tagArr [BTB_ENTRIES];
    logic [31:0]            targetArr [BTB_ENTRIES];
    logic                   branchArr [BTB_ENTRIES];

    logic [IDX_BITS-1:0]    rdIdx;
    logic [IDX_BITS-1:0]    wrIdx;
    logic                   write;

    // Word address splits into index and tag
    assign rdIdx = lookupPc_i[IDX_BITS+1:2];
    assign wrIdx = train.pc[IDX_BITS+1:2];

    assign hit_o      = entryValid[rdIdx] && (tagArr[rdIdx] == lookupPc_i[31:IDX_BITS+2]);
    assign target_o   = targetArr[rdIdx];
    assign isBranch_o = branchArr[rdIdx];

    // Not-taken branches leave the entry alone
    assign write = train.valid && (!train.isBranch || train.taken);

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (write) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            tagArr[wrIdx]    <= train.pc[31:IDX_BITS+2];
            targetArr[wrIdx] <= train.target;
            branchArr[wrIdx] <= train.isBranch;
        end
    end

endmodule

`default_nettype wire

// File: gsharePredictor.sv
/*
 * Gshare direction predictor
 * Global history XOR PC word address indexes a table of
 * two-bit saturating counters, trained at resolve
 */
`timescale 1ns/10ps
`default_nettype none

module gsharePredictor #(
    parameter int GHR_BITS    = 3,
    parameter int PHT_ENTRIES = 1024
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [31:0]                    lookupPc_i,
    output logic                                taken_o,
    output logic [$clog2(PHT_ENTRIES)-1:0]      index_o,
    trainBus.receiver                           train
);
    import bpPkg::*;

    localparam int IDX_BITS = $clog2(PHT_ENTRIES);

    logic [1:0]          pht [PHT_ENTRIES];
    logic [GHR_BITS-1:0] ghr;
    logic [1:0]          curCount;
    logic [1:0]          nextCount;

    assign index_o = lookupPc_i[IDX_BITS+1:2] ^ IDX_BITS'(ghr);
    assign taken_o = pht[index_o][1];

    // One step toward the outcome, held at the ends
    assign curCount = pht[train.phtIndex];
    always_comb begin
        nextCount = curCount;
        if (train.taken && curCount != CNT_STRONG_T) begin
            nextCount = curCount + 2'd1;
        end else if (!train.taken && curCount != CNT_STRONG_NT) begin
            nextCount = curCount - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht[i] <= CNT_WEAK_NT;
            end
        end else if (train.valid && train.isBranch) begin
            ghr                 <= {ghr[GHR_BITS-2:0], train.taken};
            pht[train.phtIndex] <= nextCount;
        end
    end

    // Index travelled through two stages and must still address the table
    trainIdxInRange: assert property (@(posedge clk) disable iff (reset)
        train.valid && train.isBranch |-> int'(train.phtIndex) < PHT_ENTRIES);

endmodule

`default_nettype wire

// File: fetchStage.sv
/*
 * Fetch stage
 * Program counter, prediction from BTB and PHT lookups,
 * next-PC selection and launch of the strobed instruction
 */
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
    parameter int PHT_ENTRIES = 1024
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic                           instrValid_i,
    input  wire logic [31:0]                    instr_i,
    input  wire logic                           actualTaken_i,
    input  wire logic                           btbHit_i,
    input  wire logic [31:0]                    btbTarget_i,
    input  wire logic                           btbIsBranch_i,
    input  wire logic                           phtTaken_i,
    input  wire logic [$clog2(PHT_ENTRIES)-1:0] phtIndex_i,
    input  wire logic                           redirectValid_i,
    input  wire logic [31:0]                    redirectPc_i,
    output logic [31:0]                         pc_o,
    output logic                                predTaken_o,
    output logic [31:0]                         predTarget_o,
    stageBus.sender                             outBus
);
    import bpPkg::*;

    logic [31:0] pc;
    logic [31:0] pcPlus4;
    logic [31:0] pcNext;

    assign pcPlus4 = pc + 32'd4;

    // Jumps always taken, branches follow the counter
    assign predTaken_o  = btbHit_i && (!btbIsBranch_i || phtTaken_i);
    assign predTarget_o = btbTarget_i;
    assign pc_o         = pc;

    always_comb begin
        if (redirectValid_i) begin
            pcNext = redirectPc_i;
        end else if (!instrValid_i) begin
            pcNext = pc;
        end else if (predTaken_o) begin
            pcNext = btbTarget_i;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assign outBus.valid       = instrValid_i;
    assign outBus.pc          = pc;
    assign outBus.instr       = instr_i;
    assign outBus.actualTaken = actualTaken_i;
    assign outBus.predTaken   = predTaken_o;
    assign outBus.predTarget  = btbTarget_i;
    assign outBus.phtIndex    = phtIndex_i;
    assign outBus.target      = '0;

    // BTB targets and redirects keep the PC aligned
    pcAligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00 |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: decodeStage.sv
/*
 * Decode stage
 * Registers the fetched instruction, extracts the B-type
 * or J-type offset and forms the branch target
 */
`timescale 1ns/10ps
`default_nettype none

module decodeStage #(
    parameter int PHT_ENTRIES = 1024
) (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic flush_i,
    stageBus.receiver inBus,
    stageBus.sender   outBus
);
    import bpPkg::*;

    localparam int IDX_BITS = $clog2(PHT_ENTRIES);

    logic                validQ;
    logic [31:0]         pcQ;
    brFormat_u           instrQ;
    logic                actualQ;
    logic                predTakenQ;
    logic [31:0]         predTargetQ;
    logic [IDX_BITS-1:0] phtIndexQ;
    logic [31:0]         offset;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inBus.valid;
        end
    end

    always_ff @(posedge clk) begin
        pcQ         <= inBus.pc;
        instrQ      <= inBus.instr;
        actualQ     <= inBus.actualTaken;
        predTakenQ  <= inBus.predTaken;
        predTargetQ <= inBus.predTarget;
        phtIndexQ   <= inBus.phtIndex;
    end

    // Immediate layout depends on the format
    always_comb begin
        if (instrQ.jType.opcode == OP_JAL) begin
            offset = {{11{instrQ.jType.imm20}}, instrQ.jType.imm20, instrQ.jType.imm19_12,
                      instrQ.jType.imm11, instrQ.jType.imm10_1, 1'b0};
        end else begin
            offset = {{19{instrQ.bType.imm12}}, instrQ.bType.imm12, instrQ.bType.imm11,
                      instrQ.bType.imm10_5, instrQ.bType.imm4_1, 1'b0};
        end
    end

    assign outBus.valid       = validQ;
    assign outBus.pc          = pcQ;
    assign outBus.instr       = instrQ;
    assign outBus.actualTaken = actualQ;
    assign outBus.predTaken   = predTakenQ;
    assign outBus.predTarget  = predTargetQ;
    assign outBus.phtIndex    = phtIndexQ;
    assign outBus.target      = pcQ + offset;

endmodule

`default_nettype wire

// File: resolveStage.sv
/*
 * Resolve stage
 * Compares the actual outcome with the prediction, redirects
 * fetch on a misprediction and trains the predictor
 */
`timescale 1ns/10ps
`default_nettype none

module resolveStage #(
    parameter int PHT_ENTRIES = 1024
) (
    input  wire logic   clk,
    input  wire logic   reset,
    output logic        redirectValid_o,
    output logic [31:0] redirectPc_o,
    output logic        flush_o,
    stageBus.receiver   inBus,
    trainBus.sender     train
);
    import bpPkg::*;

    localparam int IDX_BITS = $clog2(PHT_ENTRIES);

    logic                validQ;
    logic [31:0]         pcQ;
    logic [6:0]          opcodeQ;
    logic                actualQ;
    logic                predTakenQ;
    logic [31:0]         predTargetQ;
    logic [31:0]         targetQ;
    logic [IDX_BITS-1:0] phtIndexQ;

    logic                isBranch;
    logic                isJump;
    logic                taken;
    logic                mispredict;

    // A redirect also drops the younger item arriving from decode
    always_ff @(posedge clk) begin
        if (reset || mispredict) begin
            validQ <= 1'b0;
        end else begin
            validQ <= inBus.valid;
        end
    end

    always_ff @(posedge clk) begin
        pcQ         <= inBus.pc;
        opcodeQ     <= inBus.instr[6:0];
        actualQ     <= inBus.actualTaken;
        predTakenQ  <= inBus.predTaken;
        predTargetQ <= inBus.predTarget;
        targetQ     <= inBus.target;
        phtIndexQ   <= inBus.phtIndex;
    end

    assign isBranch = (opcodeQ == OP_BRANCH);
    assign isJump   = (opcodeQ == OP_JAL);

    // Anything other than a branch or jump falls through
    assign taken = isJump || (isBranch && actualQ);

    assign mispredict = validQ && ((predTakenQ != taken) ||
                                   (predTakenQ && taken && predTargetQ != targetQ));

    assign redirectValid_o = mispredict;
    assign redirectPc_o    = taken ? targetQ : pcQ + 32'd4;
    assign flush_o         = mispredict;

    assign train.valid    = validQ && (isBranch || isJump);
    assign train.pc       = pcQ;
    assign train.target   = targetQ;
    assign train.isBranch = isBranch;
    assign train.taken    = taken;
    assign train.phtIndex = phtIndexQ;

    // Redirect needs a live item from decode and lands on a word boundary
    redirectOnValid: assert property (@(posedge clk) disable iff (reset)
        redirectValid_o |-> $past(inBus.valid) && redirectPc_o[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: bpFrontEnd.sv
/*
 * Branch predicting front end, top level
 * Fetch, decode and resolve stages around a BTB and gshare PHT
 */
`timescale 1ns/10ps
`default_nettype none

module bpFrontEnd #(
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 3,
    parameter int PHT_ENTRIES = 1024
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        instrValid_i,
    input  wire logic [31:0] instr_i,
    input  wire logic        actualTaken_i,
    output logic [31:0]      fetchPc_o,
    output logic             predTaken_o,
    output logic [31:0]      predTarget_o,
    output logic             redirectValid_o,
    output logic [31:0]      redirectPc_o
);
    logic                           btbHit;
    logic [31:0]                    btbTarget;
    logic                           btbIsBranch;
    logic                           phtTaken;
    logic [$clog2(PHT_ENTRIES)-1:0] phtIndex;
    logic                           flush;

    stageBus #(.PHT_ENTRIES(PHT_ENTRIES)) fetchToDecode ();
    stageBus #(.PHT_ENTRIES(PHT_ENTRIES)) decodeToResolve ();
    trainBus #(.PHT_ENTRIES(PHT_ENTRIES)) trainLink ();

    fetchStage #(.PHT_ENTRIES(PHT_ENTRIES)) fetch (
        .clk(clk), .reset(reset),
        .instrValid_i(instrValid_i), .instr_i(instr_i), .actualTaken_i(actualTaken_i),
        .btbHit_i(btbHit), .btbTarget_i(btbTarget), .btbIsBranch_i(btbIsBranch),
        .phtTaken_i(phtTaken), .phtIndex_i(phtIndex),
        .redirectValid_i(redirectValid_o), .redirectPc_i(redirectPc_o),
        .pc_o(fetchPc_o), .predTaken_o(predTaken_o), .predTarget_o(predTarget_o),
        .outBus(fetchToDecode.sender)
    );

    decodeStage #(.PHT_ENTRIES(PHT_ENTRIES)) decode (
        .clk(clk), .reset(reset), .flush_i(flush),
        .inBus(fetchToDecode.receiver), .outBus(decodeToResolve.sender)
    );

    resolveStage #(.PHT_ENTRIES(PHT_ENTRIES)) resolve (
        .clk(clk), .reset(reset),
        .redirectValid_o(redirectValid_o), .redirectPc_o(redirectPc_o), .flush_o(flush),
        .inBus(decodeToResolve.receiver), .train(trainLink.sender)
    );

    branchTargetBuffer #(.BTB_ENTRIES(BTB_ENTRIES)) btb (
        .clk(clk), .reset(reset), .lookupPc_i(fetchPc_o),
        .hit_o(btbHit), .target_o(btbTarget), .isBranch_o(btbIsBranch),
        .train(trainLink.receiver)
    );

    gsharePredictor #(.GHR_BITS(GHR_BITS), .PHT_ENTRIES(PHT_ENTRIES)) pht (
        .clk(clk), .reset(reset), .lookupPc_i(fetchPc_o),
        .taken_o(phtTaken), .index_o(phtIndex),
        .train(trainLink.receiver)
    );

endmodule

`default_nettype wire

// File: bpChecker.sv
/*
 * Reference model and scoreboard for the front end
 * Keeps its own BTB, counters and history, follows strobed
 * fetches to resolve and compares predictions and redirects
 */
`timescale 1ns/10ps
`default_nettype none

module bpChecker #(
    parameter int BTB_ENTRIES = 32,
    parameter int GHR_BITS    = 3,
    parameter int PHT_ENTRIES = 1024
) (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic        instrValid_i,
    input  wire logic [31:0] instr_i,
    input  wire logic        actualTaken_i,
    input  wire logic [31:0] fetchPc_i,
    input  wire logic        predTaken_i,
    input  wire logic [31:0] predTarget_i,
    input  wire logic        redirectValid_i,
    input  wire logic [31:0] redirectPc_i,
    output int               errorCount_o,
    output int               checkCount_o
);
    import bpPkg::*;

    localparam int BTB_IDX = $clog2(BTB_ENTRIES);
    localparam int PHT_IDX = $clog2(PHT_ENTRIES);

    bit                  btbValid [BTB_ENTRIES];
    logic [31:0]         btbPc [BTB_ENTRIES];
    logic [31:0]         btbTgt [BTB_ENTRIES];
    bit                  btbBr [BTB_ENTRIES];
    logic [1:0]          cnt [PHT_ENTRIES];
    logic [GHR_BITS-1:0] hist;

    // Slot 0 is decode, slot 1 is resolve
    bit                  sValid [2];
    logic [31:0]         sPc [2];
    logic [31:0]         sInstr [2];
    bit                  sActual [2];
    bit                  sPredT [2];
    logic [31:0]         sPredTgt [2];
    int                  sIdx [2];

    bit                  started;
    bit                  expNextValid;
    logic [31:0]         expNextPc;

    initial begin
        errorCount_o = 0;
        checkCount_o = 0;
    end

    // Immediates straight from the RISC-V B and J layouts
    function automatic logic [31:0] immB(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] immJ(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount_o++;
        if (expected !== actual) begin
            errorCount_o++;
            $display("Mismatch %s at %0t: expected %h, actual %h",
                     name, $time, expected, actual);
        end
    endtask

    always @(posedge clk) begin
        logic        isBr;
        logic        isJ;
        logic        taken;
        logic        mis;
        logic [31:0] target;
        logic [31:0] corrPc;
        logic        expTaken;
        int          bIdx;
        int          idx;
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) btbValid[i] = 1'b0;
            for (int i = 0; i < PHT_ENTRIES; i++) cnt[i] = CNT_WEAK_NT;
            hist         = '0;
            sValid[0]    = 1'b0;
            sValid[1]    = 1'b0;
            started      = 1'b0;
            expNextValid = 1'b0;
        end else begin
            if (!started) begin
                compare("reset pc", RESET_PC, fetchPc_i);
                started = 1'b1;
            end
            if (expNextValid) begin
                compare("next fetch pc", expNextPc, fetchPc_i);
            end

            // Resolve slot
            isBr   = sValid[1] && sInstr[1][6:0] == 7'b1100011;
            isJ    = sValid[1] && sInstr[1][6:0] == 7'b1101111;
            taken  = isJ || (isBr && sActual[1]);
            target = sPc[1] + (isJ ? immJ(sInstr[1]) : immB(sInstr[1]));
            mis    = sValid[1] && (sPredT[1] != taken ||
                                   (taken && sPredTgt[1] != target));
            corrPc = taken ? target : sPc[1] + 32'd4;
            compare("redirect valid", {31'b0, mis}, {31'b0, redirectValid_i});
            if (mis) begin
                compare("redirect pc", corrPc, redirectPc_i);
            end

            // Model lookup on the fetch PC
            bIdx     = int'(fetchPc_i[BTB_IDX+1:2]);
            idx      = int'(fetchPc_i[PHT_IDX+1:2] ^ PHT_IDX'(hist));
            expTaken = btbValid[bIdx] && btbPc[bIdx] == fetchPc_i &&
                       (!btbBr[bIdx] || cnt[idx][1]);
            if (instrValid_i) begin
                compare("predicted taken", {31'b0, expTaken}, {31'b0, predTaken_i});
                if (expTaken) begin
                    compare("predicted target", btbTgt[bIdx], predTarget_i);
                end
            end

            expNextValid = 1'b1;
            if (mis) begin
                expNextPc = corrPc;
            end else if (instrValid_i) begin
                expNextPc = expTaken ? btbTgt[bIdx] : fetchPc_i + 32'd4;
            end else begin
                expNextPc = fetchPc_i;
            end

            // Training after the lookup, as at the clock edge
            if (isJ || (isBr && taken)) begin
                btbValid[int'(sPc[1][BTB_IDX+1:2])] = 1'b1;
                btbPc[int'(sPc[1][BTB_IDX+1:2])]    = sPc[1];
                btbTgt[int'(sPc[1][BTB_IDX+1:2])]   = target;
                btbBr[int'(sPc[1][BTB_IDX+1:2])]    = isBr;
            end
            if (isBr) begin
                if (taken && cnt[sIdx[1]] != 2'b11) begin
                    cnt[sIdx[1]] = cnt[sIdx[1]] + 2'd1;
                end else if (!taken && cnt[sIdx[1]] != 2'b00) begin
                    cnt[sIdx[1]] = cnt[sIdx[1]] - 2'd1;
                end
                hist = {hist[GHR_BITS-2:0], taken};
            end

            // Advance the pipeline, a redirect flushes both slots
            if (mis) begin
                sValid[0] = 1'b0;
                sValid[1] = 1'b0;
            end else begin
                sValid[1]   = sValid[0];
                sPc[1]      = sPc[0];
                sInstr[1]   = sInstr[0];
                sActual[1]  = sActual[0];
                sPredT[1]   = sPredT[0];
                sPredTgt[1] = sPredTgt[0];
                sIdx[1]     = sIdx[0];
                sValid[0]   = instrValid_i;
                sPc[0]      = fetchPc_i;
                sInstr[0]   = instr_i;
                sActual[0]  = actualTaken_i;
                sPredT[0]   = expTaken;
                sPredTgt[0] = btbTgt[bIdx];
                sIdx[0]     = idx;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_bpFrontEnd.sv
/*
 * Testbench for the branch predicting front end
 * Plays the instruction cache from a correct-path trace,
 * feeds NOPs on wrong-path addresses and inserts idle cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_bpFrontEnd;
    import bpPkg::*;

    localparam int BTB_ENTRIES = 32;
    localparam int GHR_BITS    = 3;
    localparam int PHT_ENTRIES = 1024;
    localparam int MAX_ENTRIES = 64;
    localparam logic [31:0] NOP = 32'h0000_0013;

    logic        clk;
    logic        reset;
    logic        instrValid;
    logic [31:0] instr;
    logic        actualTaken;
    logic [31:0] fetchPc;
    logic        predTaken;
    logic [31:0] predTarget;
    logic        redirectValid;
    logic [31:0] redirectPc;

    logic [31:0] tracePc [MAX_ENTRIES];
    logic [31:0] traceInstr [MAX_ENTRIES];
    logic        traceTaken [MAX_ENTRIES];
    int          traceLen = 0;
    int          nextEntry = 0;
    int          tbErrors = 0;
    int          errorCount;
    int          checkCount;
    bit          traceLoaded = 1'b0;

    bpFrontEnd #(
        .BTB_ENTRIES(BTB_ENTRIES), .GHR_BITS(GHR_BITS), .PHT_ENTRIES(PHT_ENTRIES)
    ) uut (
        .clk(clk), .reset(reset), .instrValid_i(instrValid), .instr_i(instr),
        .actualTaken_i(actualTaken), .fetchPc_o(fetchPc), .predTaken_o(predTaken),
        .predTarget_o(predTarget), .redirectValid_o(redirectValid),
        .redirectPc_o(redirectPc)
    );

    bpChecker #(
        .BTB_ENTRIES(BTB_ENTRIES), .GHR_BITS(GHR_BITS), .PHT_ENTRIES(PHT_ENTRIES)
    ) scoreboard (
        .clk(clk), .reset(reset), .instrValid_i(instrValid), .instr_i(instr),
        .actualTaken_i(actualTaken), .fetchPc_i(fetchPc), .predTaken_i(predTaken),
        .predTarget_i(predTarget), .redirectValid_i(redirectValid),
        .redirectPc_i(redirectPc), .errorCount_o(errorCount), .checkCount_o(checkCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Lines that do not hold three hex fields are comments
    task automatic loadTrace();
        int          fd;
        int          fields;
        string       line;
        logic [31:0] pcVal;
        logic [31:0] wordVal;
        logic [31:0] takenVal;
        fd = $fopen("bp_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bp_stim.txt");
            return;
        end
        while (!$feof(fd) && traceLen < MAX_ENTRIES) begin
            if ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h", pcVal, wordVal, takenVal);
                if (fields == 3) begin
                    tracePc[traceLen]    = pcVal;
                    traceInstr[traceLen] = wordVal;
                    traceTaken[traceLen] = takenVal[0];
                    traceLen++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic printSummary();
        $display("Checks: %0d, mismatches: %0d, testbench errors: %0d, entries fed: %0d of %0d",
                 checkCount, errorCount, tbErrors, nextEntry, traceLen);
    endtask

    initial begin
        reset       = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        actualTaken = 1'b0;
        void'($urandom(32'h5402_c1f5));
        loadTrace();
        traceLoaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (traceLen == 0) begin
            $display("The stimulus file holds no trace entries");
            tbErrors++;
        end
        while (nextEntry < traceLen) begin
            if ($urandom % 4 == 0) begin
                instrValid = 1'b0;
            end else if (fetchPc == tracePc[nextEntry] && !redirectValid) begin
                instrValid  = 1'b1;
                instr       = traceInstr[nextEntry];
                actualTaken = traceTaken[nextEntry];
                nextEntry++;
            end else begin
                // Wrong-path address or a fetch dropped by the redirect
                instrValid  = 1'b1;
                instr       = NOP;
                actualTaken = 1'b0;
            end
            @(negedge clk);
        end
        instrValid = 1'b0;
        // Last entry resolves two edges after its strobe
        repeat (3) @(negedge clk);
        printSummary();
        if (errorCount == 0 && tbErrors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (traceLoaded);
        repeat (traceLen * 20 + 10) @(posedge clk);
        $display("Timeout: the trace was not fetched to its end in time");
        tbErrors++;
        printSummary();
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bp_stim.txt
# Correct-path trace, one instruction per line
# columns: pc (hex), instruction word (hex), actual taken bit
00000000 00000093 0
00000004 00a00113 0
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 1
00000008 00209063 0
0000000c 00c0006f 1
00000018 00418463 1
00000020 ff9ff06f 1
00000018 00418463 0
0000001c 00118193 0
00000020 ff9ff06f 1
00000018 00418463 1

// File: filelist.f
bpPkg.sv
bpIfaces.sv
branchTargetBuffer.sv
gsharePredictor.sv
fetchStage.sv
decodeStage.sv
resolveStage.sv
bpFrontEnd.sv
bpChecker.sv
tb_bpFrontEnd.sv
